/* src/mips_pkg.sv */
// MIPS core package with instruction encodings, ALU operations and the decoded control word
package mips_pkg;

    // Basic data and register types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Boot address after reset
    localparam word_t RESET_VECTOR_DEFAULT = 32'hBFC0_0000;
    // Register whose value is mirrored on register_v0
    localparam reg_addr_t REG_V0 = 5'd2;
    // Word transfers only, so every lane is enabled
    localparam logic [3:0] BE_WORD = 4'b1111;

    // Primary opcodes, real MIPS values
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // Next PC source
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;

    // Decoded instruction, consumed by control and ALU
    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;
        word_t     imm;
        logic      shift_from_reg;
        logic [4:0] shamt;
        reg_addr_t dest;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch_eq;
        logic      branch_ne;
        pc_sel_t   pc_sel;
        logic      illegal;
    } decode_t;

endpackage

/* src/mips_decoder.sv */
// Instruction decoder, maps a latched MIPS word onto the control struct
module mips_decoder (
    input  mips_pkg::word_t   instr,
    output mips_pkg::decode_t dec
);
    import mips_pkg::*;

    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic        zero_ext;

    // Instruction fields
    assign opcode = opcode_t'(instr[31:26]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = funct_t'(instr[5:0]);
    assign imm16  = instr[15:0];

    // Logical immediates are zero extended, all others sign extended
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_ADD;
        dec.pc_sel = PC_SEQ;
        dec.shamt  = shamt;
        dec.imm    = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
        // I-type writes rt unless overridden
        dec.dest   = rt;
        case (opcode)
            OP_RTYPE: begin
                dec.dest      = rd;
                dec.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    FN_SLLV: begin
                        dec.alu_op         = ALU_SLL;
                        dec.shift_from_reg = 1'b1;
                    end
                    FN_SRLV: begin
                        dec.alu_op         = ALU_SRL;
                        dec.shift_from_reg = 1'b1;
                    end
                    FN_SRAV: begin
                        dec.alu_op         = ALU_SRA;
                        dec.shift_from_reg = 1'b1;
                    end
                    // Jump through rs, no write-back
                    FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.pc_sel    = PC_REG;
                    end
                    default: begin
                        dec.reg_write = 1'b0;
                        dec.illegal   = 1'b1;
                    end
                endcase
            end
            OP_J: dec.pc_sel = PC_JUMP;
            OP_BEQ: begin
                dec.pc_sel    = PC_BRANCH;
                dec.branch_eq = 1'b1;
            end
            OP_BNE: begin
                dec.pc_sel    = PC_BRANCH;
                dec.branch_ne = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
            end
            // Address sum rs + offset for both word transfers
            OP_LW: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            OP_SW: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
        // Writes to $zero are dropped here
        dec.reg_write = dec.reg_write && (dec.dest != '0);
    end

endmodule

/* src/mips_regfile.sv */
// Register file with 32 words, two combinational read ports and one write port
module mips_regfile (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t raddr_a,
    input  mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t     rdata_a,
    output mips_pkg::word_t     rdata_b,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // Register zero never takes a write
            regs[waddr] <= wdata;
        end
    end

    // Reads see the current contents, $zero forced
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // $v0 for the register_v0 port
    assign v0 = regs[REG_V0];

endmodule

/* src/mips_alu.sv */
// Integer ALU for add, subtract, logic, shifts, compares and LUI, plus branch equality
module mips_alu (
    input  mips_pkg::decode_t dec,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   result,
    output logic              equal
);
    import mips_pkg::*;

    word_t      op_b;
    logic [4:0] sh;
    logic       lt_signed;
    logic       lt_unsigned;

    // Operand B is rt or the extended immediate
    assign op_b = dec.use_imm ? dec.imm : b;

    // Variable shifts take the amount from rs
    assign sh = dec.shift_from_reg ? a[4:0] : dec.shamt;

    // SLTIU still compares against the sign-extended immediate
    assign lt_signed   = $signed(a) < $signed(op_b);
    assign lt_unsigned = a < op_b;

    // Raw register compare for BEQ and BNE
    assign equal = (a == b);

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = a + op_b;
            ALU_SUB:  result = a - op_b;
            ALU_AND:  result = a & op_b;
            ALU_OR:   result = a | op_b;
            ALU_XOR:  result = a ^ op_b;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            // Shifts act on rt
            ALU_SLL:  result = b << sh;
            ALU_SRL:  result = b >> sh;
            ALU_SRA:  result = word_t'($signed(b) >>> sh);
            // Immediate into the upper half
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            default:  result = a + op_b;
        endcase
    end

endmodule

/* src/mips_control.sv */
// Multicycle control FSM with PC, instruction register, Avalon master and next-PC select
module mips_control #(
    parameter mips_pkg::word_t RESET_VECTOR = mips_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    output mips_pkg::word_t     instr,
    input  mips_pkg::decode_t   dec,
    input  mips_pkg::word_t     rdata_a,
    input  mips_pkg::word_t     rdata_b,
    input  mips_pkg::word_t     alu_result,
    input  logic                equal,
    output logic                we,
    output mips_pkg::reg_addr_t waddr,
    output mips_pkg::word_t     wdata,
    output mips_pkg::word_t     address,
    output logic                read,
    output logic                write,
    output mips_pkg::word_t     writedata,
    output logic [3:0]          byteenable,
    input  logic                waitrequest,
    input  mips_pkg::word_t     readdata,
    output logic                active
);
    import mips_pkg::*;

    typedef enum logic [2:0] {FETCH, LATCH, EXEC, MEM, LOAD_WB, HALTED} state_t;

    state_t state;
    state_t state_next;
    word_t  pc;
    word_t  ir;
    word_t  pc_plus4;
    word_t  pc_branch;
    word_t  pc_jump;
    word_t  pc_next;
    logic   started;
    logic   taken;
    logic   halt;

    assign instr = ir;

    // Next PC candidates
    assign pc_plus4  = pc + 32'd4;
    assign pc_branch = pc_plus4 + {dec.imm[29:0], 2'b00};
    assign pc_jump   = {pc_plus4[31:28], ir[25:0], 2'b00};
    assign taken     = (dec.branch_eq && equal) || (dec.branch_ne && !equal);
    // JR to address zero ends the program
    assign halt      = (dec.pc_sel == PC_REG) && (rdata_a == '0);

    always_comb begin
        case (dec.pc_sel)
            PC_BRANCH: pc_next = taken ? pc_branch : pc_plus4;
            PC_JUMP:   pc_next = pc_jump;
            PC_REG:    pc_next = rdata_a;
            default:   pc_next = pc_plus4;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            // Leave once the fetch is accepted
            FETCH:   if (read && !waitrequest) state_next = LATCH;
            LATCH:   state_next = EXEC;
            EXEC: begin
                if (halt) state_next = HALTED;
                else if (dec.mem_read || dec.mem_write) state_next = MEM;
                else state_next = FETCH;
            end
            MEM:     if (!waitrequest) state_next = dec.mem_read ? LOAD_WB : FETCH;
            LOAD_WB: state_next = FETCH;
            default: state_next = HALTED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH;
            pc      <= RESET_VECTOR;
            ir      <= '0;
            started <= 1'b0;
        end else begin
            state   <= state_next;
            started <= 1'b1;
            // Fetched word arrives one cycle after acceptance
            if (state == LATCH) ir <= readdata;
            if (state == EXEC) pc <= pc_next;
        end
    end

    // Bus requests, fetch in FETCH and data in MEM
    assign read       = ((state == FETCH) && started) || ((state == MEM) && dec.mem_read);
    assign write      = (state == MEM) && dec.mem_write;
    assign address    = (state == MEM) ? alu_result : pc;
    assign writedata  = rdata_b;
    assign byteenable = BE_WORD;
    assign active     = (state != HALTED);

    // ALU results retire in EXEC, loads in LOAD_WB
    assign we    = ((state == EXEC) && dec.reg_write && !dec.mem_read && !dec.illegal)
                || ((state == LOAD_WB) && dec.reg_write);
    assign waddr = dec.dest;
    assign wdata = (state == LOAD_WB) ? readdata : alu_result;

endmodule

/* src/mips_cpu_bus.sv */
// MIPS I multicycle core with a single Avalon master for fetches and data
module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = mips_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    word_t     instr;
    decode_t   dec;
    word_t     rdata_a;
    word_t     rdata_b;
    word_t     alu_result;
    logic      equal;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    // FSM, PC and bus master
    mips_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_control (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .dec         (dec),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .alu_result  (alu_result),
        .equal       (equal),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active)
    );

    mips_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // rs and rt straight from the instruction register
    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (instr[25:21]),
        .raddr_b (instr[20:16]),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .dec    (dec),
        .a      (rdata_a),
        .b      (rdata_b),
        .result (alu_result),
        .equal  (equal)
    );

endmodule

/* dv/avalon_ram_model.sv */
// Avalon memory model with a boot region, a data region and random wait states
module avalon_ram_model (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_en,
    input  mips_pkg::word_t boot_image [256],
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output logic            waitrequest,
    output mips_pkg::word_t readdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam word_t BOOT_BASE = 32'hBFC0_0000;
    localparam word_t DATA_BASE = 32'h0000_1000;

    word_t      data_mem [256];
    word_t      seed;
    word_t      seed_next;
    logic [1:0] stall_left;
    logic [7:0] index;
    logic       in_boot;
    logic       in_data;

    function automatic word_t lcg_step(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Both regions are 1 KB and aligned to their size
    assign index     = address[9:2];
    assign in_boot   = (address[31:10] == BOOT_BASE[31:10]);
    assign in_data   = (address[31:10] == DATA_BASE[31:10]);
    assign seed_next = lcg_step(seed);

    // Stall the pending request until the countdown runs out
    assign waitrequest = (read || write) && (stall_left != 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            seed       <= 32'h82341ae4;
            stall_left <= 2'd0;
            readdata   <= '0;
            // Data words start as their own address, scrambled
            for (int i = 0; i < 256; i++) begin
                data_mem[i] <= (DATA_BASE + word_t'(i * 4)) ^ 32'h5A5A_5A5A;
            end
        end else if (waitrequest) begin
            stall_left <= stall_left - 2'd1;
        end else if (read || write) begin
            // Accepted, pick the stall for the next request
            seed       <= seed_next;
            stall_left <= stall_en ? seed_next[31:30] : 2'd0;
            if (read) begin
                readdata <= in_boot ? boot_image[index] : (in_data ? data_mem[index] : '0);
            end
            if (write && in_data && (byteenable == 4'hF)) begin
                data_mem[index] <= writedata;
            end
        end
    end

endmodule

/* dv/mips_cpu_sva.sv */
// Avalon protocol and halt assertions for the MIPS core bus port
module mips_cpu_sva (
    input logic            clk,
    input logic            reset,
    input logic            active,
    input logic            read,
    input logic            write,
    input logic            waitrequest,
    input mips_pkg::word_t address,
    input mips_pkg::word_t writedata,
    input logic [3:0]      byteenable
);
    timeunit 1ns;
    timeprecision 1ps;

    no_read_with_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write are high in the same cycle");

    // A stalled request holds still until accepted
    request_stable: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
        && $stable(write) && $stable(writedata))
        else $error("request changed while waitrequest was high");

    full_word_write: assert property (@(posedge clk) disable iff (reset)
        write |-> (byteenable == 4'hF))
        else $error("write issued without all byte lanes enabled");

    // Halted core stays off the bus
    quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus request while the core is halted");

endmodule

bind mips_cpu_bus mips_cpu_sva u_sva (.*);

/* dv/mips_cpu_tb.sv */
// Directed testbench for the multicycle MIPS core on its Avalon bus port
module mips_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam word_t     BOOT_BASE = 32'hBFC0_0000;
    localparam int        TIMEOUT   = 5000;
    localparam reg_addr_t R_ZERO    = 5'd0;
    localparam reg_addr_t R_V0      = 5'd2;
    localparam reg_addr_t T0        = 5'd8;
    localparam reg_addr_t T1        = 5'd9;
    localparam reg_addr_t T2        = 5'd10;
    localparam reg_addr_t T3        = 5'd11;
    localparam reg_addr_t BASE      = 5'd16;

    logic       clk;
    logic       reset;
    logic       stall_en;
    logic       active;
    logic       read;
    logic       write;
    logic       waitrequest;
    logic [3:0] byteenable;
    word_t      register_v0;
    word_t      address;
    word_t      writedata;
    word_t      readdata;
    word_t      boot_image [256];
    word_t      expected [32];
    int         prog_len;
    int         exp_len;
    word_t      rand_state;

    mips_cpu_bus dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalon_ram_model ram (
        .clk         (clk),
        .reset       (reset),
        .stall_en    (stall_en),
        .boot_image  (boot_image),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    always #4 clk = ~clk;

    function automatic word_t lcg_step(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // MIPS instruction formats
    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input logic [25:0] target);
        return {6'd2, target};
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act == exp)
        else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_program();
        prog_len = 0;
        exp_len  = 0;
        // Filler word is its own address, an illegal opcode
        for (int i = 0; i < 256; i++) begin
            boot_image[i] = BOOT_BASE + word_t'(i * 4);
        end
    endtask

    task automatic emit(input word_t instr);
        boot_image[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t value);
        emit(i_type(OP_LUI, R_ZERO, rd, value[31:16]));
        emit(i_type(OP_ORI, rd, rd, value[15:0]));
    endtask

    task automatic emit_halt();
        emit(r_type(R_ZERO, R_ZERO, R_ZERO, 5'd0, FN_JR));
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        while (active && cycles < TIMEOUT) begin
            tick();
            cycles++;
        end
        if (active) begin
            $display("%s: core did not halt within %0d cycles", name, TIMEOUT);
            abort_run();
        end
    endtask

    task automatic test_reset();
        int cycles;
        clear_program();
        emit_halt();
        stall_en = 1'b0;
        reset_core();
        check_value("test_reset", 32'd1, {31'd0, active});
        check_value("test_reset", 32'd0, {31'd0, write});
        cycles = 0;
        while (!read && cycles < TIMEOUT) begin
            tick();
            cycles++;
        end
        if (!read) begin
            $display("test_reset: no fetch request after reset");
            abort_run();
        end
        check_value("test_reset", BOOT_BASE, address);
        wait_for_halt("test_reset");
    endtask

    // One ALU result into $t2, then stored to the next data word
    task automatic alu_case(input word_t instr, input word_t result);
        emit(instr);
        emit(i_type(OP_SW, BASE, T2, 16'(exp_len * 4)));
        expected[exp_len] = result;
        exp_len++;
    endtask

    task automatic test_alu();
        word_t       x;
        word_t       y;
        word_t       sx;
        word_t       zx;
        logic [15:0] imm;
        logic [4:0]  sa;
        rand_state = lcg_step(rand_state);
        x = rand_state;
        rand_state = lcg_step(rand_state);
        y = rand_state;
        rand_state = lcg_step(rand_state);
        imm = rand_state[31:16];
        sa  = rand_state[10:6];
        sx  = {{16{imm[15]}}, imm};
        zx  = {16'h0000, imm};
        clear_program();
        stall_en = 1'b0;
        emit(i_type(OP_ORI, R_ZERO, BASE, 16'h1000));
        load_const(T0, x);
        load_const(T1, y);
        alu_case(r_type(T0, T1, T2, 5'd0, FN_ADDU), x + y);
        alu_case(r_type(T0, T1, T2, 5'd0, FN_SUBU), x - y);
        alu_case(r_type(T0, T1, T2, 5'd0, FN_AND), x & y);
        alu_case(r_type(T0, T1, T2, 5'd0, FN_OR), x | y);
        alu_case(r_type(T0, T1, T2, 5'd0, FN_XOR), x ^ y);
        alu_case(r_type(T0, T1, T2, 5'd0, FN_SLT), {31'd0, $signed(x) < $signed(y)});
        alu_case(r_type(T0, T1, T2, 5'd0, FN_SLTU), {31'd0, x < y});
        alu_case(i_type(OP_ADDIU, T0, T2, imm), x + sx);
        alu_case(i_type(OP_ANDI, T0, T2, imm), x & zx);
        alu_case(i_type(OP_ORI, T0, T2, imm), x | zx);
        alu_case(i_type(OP_XORI, T0, T2, imm), x ^ zx);
        alu_case(i_type(OP_SLTI, T0, T2, imm), {31'd0, $signed(x) < $signed(sx)});
        alu_case(i_type(OP_SLTIU, T0, T2, imm), {31'd0, x < sx});
        alu_case(r_type(R_ZERO, T0, T2, sa, FN_SLL), x << sa);
        alu_case(r_type(R_ZERO, T0, T2, sa, FN_SRL), x >> sa);
        alu_case(r_type(R_ZERO, T0, T2, sa, FN_SRA), $signed(x) >>> sa);
        alu_case(r_type(T1, T0, T2, 5'd0, FN_SLLV), x << y[4:0]);
        alu_case(r_type(T1, T0, T2, 5'd0, FN_SRLV), x >> y[4:0]);
        alu_case(r_type(T1, T0, T2, 5'd0, FN_SRAV), $signed(x) >>> y[4:0]);
        // $zero ignores the ADDIU and still reads zero
        emit(i_type(OP_ADDIU, T0, R_ZERO, 16'h0055));
        alu_case(r_type(R_ZERO, R_ZERO, T2, 5'd0, FN_OR), 32'd0);
        emit_halt();
        reset_core();
        wait_for_halt("test_alu");
        for (int k = 0; k < exp_len; k++) begin
            check_value($sformatf("test_alu word %0d", k), expected[k], ram.data_mem[k]);
        end
    endtask

    task automatic test_load_store();
        word_t sum;
        clear_program();
        stall_en = 1'b1;
        sum = '0;
        emit(i_type(OP_ORI, R_ZERO, BASE, 16'h1000));
        for (int k = 0; k < 4; k++) begin
            rand_state = lcg_step(rand_state);
            expected[k] = rand_state;
            load_const(T0, rand_state);
            emit(i_type(OP_SW, BASE, T0, 16'(128 + k * 4)));
        end
        // Checksum is the wrapping sum of the reloaded words
        for (int k = 0; k < 4; k++) begin
            emit(i_type(OP_LW, BASE, T3, 16'(128 + k * 4)));
            emit(r_type(R_V0, T3, R_V0, 5'd0, FN_ADDU));
            sum = sum + expected[k];
        end
        emit(i_type(OP_SW, BASE, R_V0, 16'd144));
        emit_halt();
        reset_core();
        wait_for_halt("test_load_store");
        check_value("test_load_store", sum, register_v0);
        for (int k = 0; k < 4; k++) begin
            check_value("test_load_store", expected[k], ram.data_mem[32 + k]);
        end
        check_value("test_load_store", sum, ram.data_mem[36]);
    endtask

    task automatic test_branch_jump();
        word_t target;
        target = BOOT_BASE + 32'd60;
        clear_program();
        stall_en = 1'b1;
        emit(i_type(OP_ADDIU, R_ZERO, T0, 16'd5));
        emit(i_type(OP_ADDIU, R_ZERO, T1, 16'd5));
        emit(i_type(OP_ADDIU, R_ZERO, T2, 16'd7));
        // Taken BEQ skips marker 1
        emit(i_type(OP_BEQ, T0, T1, 16'd1));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd1));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd2));
        emit(i_type(OP_BNE, T0, T2, 16'd1));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd4));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd8));
        // Not taken, both fall through
        emit(i_type(OP_BEQ, T0, T2, 16'd1));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd16));
        emit(i_type(OP_BNE, T0, T1, 16'd1));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd32));
        // J to word 15 skips marker 64
        emit(j_type(target[27:2]));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd64));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd128));
        // Backward BNE loop, three passes of marker 256
        emit(i_type(OP_ADDIU, R_ZERO, T3, 16'd3));
        emit(i_type(OP_ADDIU, R_V0, R_V0, 16'd256));
        emit(i_type(OP_ADDIU, T3, T3, 16'hFFFF));
        emit(i_type(OP_BNE, T3, R_ZERO, 16'hFFFD));
        emit_halt();
        reset_core();
        wait_for_halt("test_branch_jump");
        check_value("test_branch_jump", 32'd2 + 32'd8 + 32'd16 + 32'd32 + 32'd128 + 32'd768,
                    register_v0);
    endtask

    task automatic test_halt();
        clear_program();
        stall_en = 1'b1;
        emit(i_type(OP_ADDIU, R_ZERO, R_V0, 16'h1234));
        emit_halt();
        reset_core();
        wait_for_halt("test_halt");
        repeat (50) begin
            tick();
            check_value("test_halt", 32'd0, {31'd0, active});
            check_value("test_halt", 32'd0, {30'd0, read, write});
            check_value("test_halt", 32'h0000_1234, register_v0);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        stall_en   = 1'b0;
        rand_state = 32'h82341ae4;
        clear_program();
        test_reset();
        test_alu();
        test_load_store();
        test_branch_jump();
        test_halt();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* mips_cpu.f */
src/mips_pkg.sv
src/mips_decoder.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_control.sv
src/mips_cpu_bus.sv
dv/avalon_ram_model.sv
dv/mips_cpu_sva.sv
dv/mips_cpu_tb.sv

/* Makefile */
RTL = src/mips_pkg.sv src/mips_decoder.sv src/mips_regfile.sv src/mips_alu.sv \
      src/mips_control.sv src/mips_cpu_bus.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module mips_cpu_bus $(RTL)

sim:
	verilator --binary --timing --assert -f mips_cpu.f --top-module mips_cpu_tb \
		-Mdir obj_dir -o mips_cpu_sim
	./obj_dir/mips_cpu_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir
